// ==== hw/pipeTypesPkg.sv ====
// pipeline records and bus types
`default_nettype none

package pipeTypesPkg;

    typedef enum logic [2:0] {
        ldNone,
        ldLb,
        ldLbu,
        ldLh,
        ldLhu,
        ldLw
    } loadKind;

    typedef enum logic [1:0] {
        stNone,
        stSb,
        stSh,
        stSw
    } storeKind;

    typedef enum logic [1:0] {
        copNone,
        copMfc0,
        copMtc0,
        copEret
    } cp0Op;

    // one instruction handed over by execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] aluOut;      // data address, or plain alu result
        logic [31:0] storeData;   // rt value, also the mtc0 source
        logic [4:0]  dst;
        logic        regWrite;
        logic [4:0]  cp0Sel;
        loadKind     loadKind;
        storeKind    storeKind;
        cp0Op        cp0Op;
        logic        inDelaySlot;
        logic        ovf;         // flags raised in execute
        logic        sys;
        logic        brk;
        logic        ri;
    } exeToMem;

    typedef struct packed {
        logic        valid;
        logic [4:0]  dst;
        logic        regWrite;
        logic [31:0] result;
    } memToWb;

    typedef struct packed {
        logic [31:0] paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  pstrb;
        logic [31:0] pwdata;
    } apbReq;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apbRsp;

    typedef struct packed {
        logic [31:0] paddr;
        logic        aligned;
        logic        adel;
        logic        ades;
    } dataAccess;

endpackage

`default_nettype wire

// ==== hw/cp0DefsPkg.sv ====
// cp0 numbers, codes and vectors
`default_nettype none

package cp0DefsPkg;

    // register numbers as seen in the rd field of mfc0/mtc0
    localparam logic [4:0] cp0BadVAddr = 5'd8;
    localparam logic [4:0] cp0Status   = 5'd12;
    localparam logic [4:0] cp0Cause    = 5'd13;
    localparam logic [4:0] cp0Epc      = 5'd14;

    localparam logic [4:0] excInt  = 5'd0;
    localparam logic [4:0] excAdel = 5'd4;
    localparam logic [4:0] excAdes = 5'd5;
    localparam logic [4:0] excSys  = 5'd8;
    localparam logic [4:0] excBp   = 5'd9;
    localparam logic [4:0] excRi   = 5'd10;
    localparam logic [4:0] excOv   = 5'd12;

    localparam logic [31:0] vecBoot   = 32'hBFC0_0380;
    localparam logic [31:0] vecNormal = 32'h8000_0180;

    localparam logic [31:0] kseg0Base = 32'h8000_0000;
    localparam logic [31:0] kseg1Base = 32'hA000_0000;

    // status and cause bit positions
    localparam int statusIeBit  = 0;
    localparam int statusExlBit = 1;
    localparam int statusBevBit = 22;
    localparam int causeBdBit   = 31;

    localparam logic [31:0] statusReset = 32'h0040_0000;    // bev only

    // software writable bits: bev, im7..0, exl, ie / ip1..0
    localparam logic [31:0] statusWrMask = 32'h0040_FF03;
    localparam logic [31:0] causeWrMask  = 32'h0000_0300;

endpackage

`default_nettype wire

// ==== hw/memPipeReg.sv ====
// execute to memory stage register
`default_nettype none

module memPipeReg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  hold,
    input  logic                  flush,
    input  pipeTypesPkg::exeToMem exeIn,
    output pipeTypesPkg::exeToMem memInstr
);

    // flush wins over hold, a flushed slot becomes a bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            memInstr <= '0;
        end else if (!hold) begin
            memInstr <= exeIn;
        end
    end

endmodule

`default_nettype wire

// ==== hw/addrTranslate.sv ====
// fixed segment mapping and alignment
`default_nettype none

module addrTranslate (
    input  pipeTypesPkg::exeToMem   memInstr,
    output pipeTypesPkg::dataAccess access
);
    import pipeTypesPkg::*;
    import cp0DefsPkg::*;

    logic [31:0] vaddr;
    logic        isLoad;
    logic        isStore;
    logic        isHalf;
    logic        isWord;
    logic        misaligned;

    assign vaddr   = memInstr.aluOut;
    assign isLoad  = memInstr.loadKind != ldNone;
    assign isStore = memInstr.storeKind != stNone;

    assign isHalf = memInstr.loadKind == ldLh || memInstr.loadKind == ldLhu
                    || memInstr.storeKind == stSh;
    assign isWord = memInstr.loadKind == ldLw || memInstr.storeKind == stSw;

    assign misaligned = (isHalf && vaddr[0]) || (isWord && vaddr[1:0] != 2'b00);

    always_comb begin
        case (vaddr[31:29])
            3'b100:  access.paddr = vaddr - kseg0Base;   // kseg0
            3'b101:  access.paddr = vaddr - kseg1Base;   // kseg1
            default: access.paddr = vaddr;               // kuseg, kseg2/3 unmapped here
        endcase
    end

    assign access.aligned = !misaligned;
    assign access.adel    = isLoad && misaligned;
    assign access.ades    = isStore && misaligned;

endmodule

`default_nettype wire

// ==== hw/dataBusMaster.sv ====
// apb master for a single load or store
`default_nettype none

module dataBusMaster (
    input  logic                    clk,
    input  logic                    rst,
    input  pipeTypesPkg::exeToMem   memInstr,
    input  pipeTypesPkg::dataAccess access,
    input  logic                    kill,
    output pipeTypesPkg::apbReq     apbReq,
    input  pipeTypesPkg::apbRsp     apbRsp,
    output logic                    busy,
    output logic [31:0]             loadData
);
    import pipeTypesPkg::*;

    typedef enum logic [1:0] {
        busIdle,
        busSetup,
        busAccess,
        busDone
    } busState;

    busState     state;
    busState     phase;     // what the bus is doing this cycle
    logic        isLoad;
    logic        isStore;
    logic        start;
    logic [1:0]  offs;
    logic [7:0]  rdByte;
    logic [15:0] rdHalf;

    assign isLoad  = memInstr.loadKind != ldNone;
    assign isStore = memInstr.storeKind != stNone;
    assign start   = memInstr.valid && (isLoad || isStore) && access.aligned && !kill;
    assign offs    = access.paddr[1:0];

    // setup is the instruction's first cycle, done is the access cycle seeing pready
    always_comb begin
        phase = state;
        case (state)
            busIdle:   if (start) phase = busSetup;
            busAccess: if (apbRsp.pready) phase = busDone;
            default:   phase = busIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= busIdle;
        end else if (phase == busSetup || phase == busAccess) begin
            state <= busAccess;
        end else begin
            state <= busIdle;
        end
    end

    assign busy = phase == busSetup || phase == busAccess;

    assign apbReq.psel    = phase != busIdle;
    assign apbReq.penable = phase == busAccess || phase == busDone;
    assign apbReq.paddr   = access.paddr;
    assign apbReq.pwrite  = isStore;

    always_comb begin
        apbReq.pstrb  = 4'b0000;    // reads carry no strobes
        apbReq.pwdata = memInstr.storeData;
        case (memInstr.storeKind)
            stSb: begin
                apbReq.pstrb  = 4'b0001 << offs;
                apbReq.pwdata = {4{memInstr.storeData[7:0]}};
            end
            stSh: begin
                apbReq.pstrb  = offs[1] ? 4'b1100 : 4'b0011;
                apbReq.pwdata = {2{memInstr.storeData[15:0]}};
            end
            stSw:    apbReq.pstrb = 4'b1111;
            default: apbReq.pstrb = 4'b0000;
        endcase
    end

    // lane select then extend
    always_comb begin
        case (offs)
            2'd0:    rdByte = apbRsp.prdata[7:0];
            2'd1:    rdByte = apbRsp.prdata[15:8];
            2'd2:    rdByte = apbRsp.prdata[23:16];
            default: rdByte = apbRsp.prdata[31:24];
        endcase
        rdHalf = offs[1] ? apbRsp.prdata[31:16] : apbRsp.prdata[15:0];

        case (memInstr.loadKind)
            ldLb:    loadData = {{24{rdByte[7]}}, rdByte};
            ldLbu:   loadData = {24'd0, rdByte};
            ldLh:    loadData = {{16{rdHalf[15]}}, rdHalf};
            ldLhu:   loadData = {16'd0, rdHalf};
            default: loadData = apbRsp.prdata;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/exceptionUnit.sv ====
// exception priority and vector select
`default_nettype none

module exceptionUnit (
    input  pipeTypesPkg::exeToMem   memInstr,
    input  pipeTypesPkg::dataAccess access,
    input  logic                    complete,
    input  logic [31:0]             status,
    input  logic [31:0]             cause,
    input  logic [31:0]             epc,
    output logic                    takeExc,
    output logic [4:0]              excCode,
    output logic                    isEret,
    output logic                    flushException,
    output logic [31:0]             exceptionVector
);
    import pipeTypesPkg::*;
    import cp0DefsPkg::*;

    logic intPending;

    assign intPending = status[statusIeBit] && !status[statusExlBit]
                        && (cause[15:8] & status[15:8]) != 8'd0;

    always_comb begin
        takeExc = memInstr.valid;
        excCode = excInt;
        if (intPending)         excCode = excInt;
        else if (access.adel)   excCode = excAdel;
        else if (access.ades)   excCode = excAdes;
        else if (memInstr.ri)   excCode = excRi;
        else if (memInstr.ovf)  excCode = excOv;
        else if (memInstr.sys)  excCode = excSys;
        else if (memInstr.brk)  excCode = excBp;
        else                    takeExc = 1'b0;
    end

    // any exception outranks the eret itself
    assign isEret = memInstr.valid && memInstr.cp0Op == copEret && !takeExc;

    assign flushException = complete && (takeExc || isEret);

    always_comb begin
        if (isEret) begin
            exceptionVector = epc;
        end else if (status[statusBevBit]) begin
            exceptionVector = vecBoot;
        end else begin
            exceptionVector = vecNormal;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cp0Regs.sv ====
// cp0 subset: badvaddr, status, cause, epc
`default_nettype none

module cp0Regs (
    input  logic                  clk,
    input  logic                  rst,
    input  pipeTypesPkg::exeToMem memInstr,
    input  logic                  complete,
    input  logic                  takeExc,
    input  logic [4:0]            excCode,
    input  logic                  isEret,
    input  logic [5:0]            hwInt,
    output logic [31:0]           rdData,
    output logic [31:0]           status,
    output logic [31:0]           cause,
    output logic [31:0]           epc
);
    import pipeTypesPkg::*;
    import cp0DefsPkg::*;

    logic [31:0] badVAddr;
    logic        commitExc;
    logic        commitEret;
    logic        commitMtc0;
    logic        addrErr;
    logic [31:0] wrData;

    assign commitExc  = complete && takeExc;
    assign commitEret = complete && isEret;
    assign commitMtc0 = complete && !takeExc && memInstr.cp0Op == copMtc0;
    assign addrErr    = excCode == excAdel || excCode == excAdes;
    assign wrData     = memInstr.storeData;    // rt value from execute

    always_ff @(posedge clk) begin
        if (rst) begin
            status   <= statusReset;
            cause    <= '0;
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            if (commitMtc0) begin
                case (memInstr.cp0Sel)
                    cp0Status: status <= (status & ~statusWrMask) | (wrData & statusWrMask);
                    cp0Cause:  cause <= (cause & ~causeWrMask) | (wrData & causeWrMask);
                    cp0Epc:    epc <= wrData;
                    default:   ;    // badvaddr is read only
                endcase
            end

            if (commitExc) begin
                epc                  <= memInstr.inDelaySlot ? memInstr.pc - 32'd4
                                                             : memInstr.pc;
                cause[causeBdBit]    <= memInstr.inDelaySlot;
                cause[6:2]           <= excCode;
                status[statusExlBit] <= 1'b1;
                if (addrErr) begin
                    badVAddr <= memInstr.aluOut;
                end
            end

            if (commitEret) begin
                status[statusExlBit] <= 1'b0;
            end

            cause[15:10] <= hwInt;    // ip7..2 follow the pins
        end
    end

    always_comb begin
        case (memInstr.cp0Sel)
            cp0BadVAddr: rdData = badVAddr;
            cp0Status:   rdData = status;
            cp0Cause:    rdData = cause;
            cp0Epc:      rdData = epc;
            default:     rdData = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/memStageTop.sv ====
// mips32 memory stage top
`default_nettype none

module memStageTop (
    input  logic                  clk,
    input  logic                  rst,
    input  pipeTypesPkg::exeToMem exeIn,
    input  logic [5:0]            hwInt,
    output pipeTypesPkg::apbReq   apbReq,
    input  pipeTypesPkg::apbRsp   apbRsp,
    output pipeTypesPkg::memToWb  memOut,
    output logic                  memStall,
    output logic                  flushException,
    output logic [31:0]           exceptionVector,
    output logic [31:0]           epc
);
    import pipeTypesPkg::*;

    pipeTypesPkg::exeToMem   memInstr;
    pipeTypesPkg::dataAccess access;
    logic [31:0]             loadData;
    logic [31:0]             rdData;
    logic [31:0]             status;
    logic [31:0]             cause;
    logic [4:0]              excCode;
    logic                    takeExc;
    logic                    isEret;
    logic                    busy;
    logic                    complete;
    logic [31:0]             wbResult;

    assign memStall = busy;
    assign complete = memInstr.valid && !busy;    // last cycle of the instruction here

    memPipeReg uMemPipeReg (
        .clk      (clk),
        .rst      (rst),
        .hold     (memStall),
        .flush    (flushException),
        .exeIn    (exeIn),
        .memInstr (memInstr)
    );

    addrTranslate uAddrTranslate (
        .memInstr (memInstr),
        .access   (access)
    );

    dataBusMaster uDataBusMaster (
        .clk      (clk),
        .rst      (rst),
        .memInstr (memInstr),
        .access   (access),
        .kill     (takeExc),    // no transfer for a faulting instruction
        .apbReq   (apbReq),
        .apbRsp   (apbRsp),
        .busy     (busy),
        .loadData (loadData)
    );

    exceptionUnit uExceptionUnit (
        .memInstr        (memInstr),
        .access          (access),
        .complete        (complete),
        .status          (status),
        .cause           (cause),
        .epc             (epc),
        .takeExc         (takeExc),
        .excCode         (excCode),
        .isEret          (isEret),
        .flushException  (flushException),
        .exceptionVector (exceptionVector)
    );

    cp0Regs uCp0Regs (
        .clk      (clk),
        .rst      (rst),
        .memInstr (memInstr),
        .complete (complete),
        .takeExc  (takeExc),
        .excCode  (excCode),
        .isEret   (isEret),
        .hwInt    (hwInt),
        .rdData   (rdData),
        .status   (status),
        .cause    (cause),
        .epc      (epc)
    );

    always_comb begin
        if (memInstr.loadKind != ldNone) begin
            wbResult = loadData;
        end else if (memInstr.cp0Op == copMfc0) begin
            wbResult = rdData;
        end else begin
            wbResult = memInstr.aluOut;
        end
    end

    // writeback record, one cycle per completed instruction
    always_ff @(posedge clk) begin
        memOut.dst      <= memInstr.dst;
        memOut.regWrite <= memInstr.regWrite && !flushException;
        memOut.result   <= wbResult;
        if (rst) begin
            memOut.valid <= 1'b0;
        end else begin
            memOut.valid <= complete;
        end
    end

endmodule

`default_nettype wire

// ==== verification/memStageChk.sv ====
// apb and pipeline protocol checks
`default_nettype none

module memStageChk (
    input logic                 clk,
    input logic                 rst,
    input pipeTypesPkg::apbReq  apbReq,
    input logic                 memStall,
    input logic                 flushException,
    input pipeTypesPkg::memToWb memOut
);
    timeunit 1ns;
    timeprecision 100ps;

    // request fields hold from setup through the last access cycle
    apbStable: assert property (@(posedge clk) disable iff (rst)
        apbReq.psel && apbReq.penable |-> $stable(apbReq.paddr) && $stable(apbReq.pwrite)
        && $stable(apbReq.pstrb) && $stable(apbReq.pwdata))
        else $error("apb request changed while psel was high");

    setupFirst: assert property (@(posedge clk) disable iff (rst)
        $rose(apbReq.penable) |-> $past(apbReq.psel && !apbReq.penable))
        else $error("penable rose without a setup cycle");

    // a flushed slot is a bubble that cannot stall
    flushBubble: assert property (@(posedge clk) disable iff (rst)
        flushException |=> !memStall)
        else $error("stage stalled right after a flush");

    wbClearAfterReset: assert property (@(posedge clk)
        rst |=> !memOut.valid)
        else $error("writeback valid high right after reset");

endmodule

`default_nettype wire

// ==== verification/memStageTb.sv ====
// memory stage random testbench
`default_nettype none

module memStageTb;
    timeunit 1ns;
    timeprecision 100ps;
    import pipeTypesPkg::*;
    import cp0DefsPkg::*;

    localparam int numInstr       = 400;
    localparam int cyclesPerInstr = 6;

    logic        clk;
    logic        rst;
    exeToMem     exeIn;
    logic [5:0]  hwInt;
    apbReq       busReq;
    apbRsp       busRsp;
    memToWb      memOut;
    logic        memStall;
    logic        flushException;
    logic [31:0] exceptionVector;
    logic [31:0] epc;

    logic [31:0] slaveMem [256];   // apb slave storage, mirrored everywhere
    logic [31:0] refMem [256];     // model view of the same memory
    logic [31:0] mStatus;
    logic [31:0] mCause;
    logic [31:0] mEpc;
    logic [31:0] mBadVAddr;
    exeToMem     pending;          // offered to the DUT, not yet taken
    exeToMem     stage;            // model of the stage register
    int          stageAge;
    logic        needBus;
    memToWb      expWb;
    int          waitCnt;
    int          issued;
    int          errors;
    int          checks;

    memStageTop UUT (
        .clk             (clk),
        .rst             (rst),
        .exeIn           (exeIn),
        .hwInt           (hwInt),
        .apbReq          (busReq),
        .apbRsp          (busRsp),
        .memOut          (memOut),
        .memStall        (memStall),
        .flushException  (flushException),
        .exceptionVector (exceptionVector),
        .epc             (epc)
    );

    bind memStageTop memStageChk uChk (
        .clk(clk), .rst(rst), .apbReq(apbReq), .memStall(memStall),
        .flushException(flushException), .memOut(memOut)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        checkValue(name, {31'd0, expected}, {31'd0, actual});
    endtask

    function automatic logic [31:0] mapAddr(input logic [31:0] va);
        if (va[31:29] == 3'b100) return va - kseg0Base;
        if (va[31:29] == 3'b101) return va - kseg1Base;
        return va;
    endfunction

    function automatic logic misalignedFor(input exeToMem i);
        logic half;
        logic word;
        half = i.loadKind == ldLh || i.loadKind == ldLhu || i.storeKind == stSh;
        word = i.loadKind == ldLw || i.storeKind == stSw;
        return (half && i.aluOut[0]) || (word && i.aluOut[1:0] != 2'b00);
    endfunction

    // {taken, code} by priority, int first
    function automatic logic [5:0] pickException(input exeToMem i);
        logic mis;
        logic intPend;
        mis = misalignedFor(i);
        intPend = mStatus[0] && !mStatus[1] && (mCause[15:8] & mStatus[15:8]) != 8'd0;
        if (!i.valid) return 6'd0;
        if (intPend) return {1'b1, excInt};
        if (mis && i.loadKind != ldNone) return {1'b1, excAdel};
        if (mis && i.storeKind != stNone) return {1'b1, excAdes};
        if (i.ri) return {1'b1, excRi};
        if (i.ovf) return {1'b1, excOv};
        if (i.sys) return {1'b1, excSys};
        if (i.brk) return {1'b1, excBp};
        return 6'd0;
    endfunction

    function automatic logic [3:0] strobeFor(input storeKind sk, input logic [1:0] off);
        case (sk)
            stSb:    return 4'b0001 << off;
            stSh:    return off[1] ? 4'b1100 : 4'b0011;
            stSw:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic logic [31:0] laneData(input storeKind sk, input logic [31:0] d);
        if (sk == stSb) return {4{d[7:0]}};
        if (sk == stSh) return {2{d[15:0]}};
        return d;
    endfunction

    function automatic logic [31:0] loadValue(input loadKind lk, input logic [31:0] word,
                                              input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (lk)
            ldLb:    return {{24{b[7]}}, b};
            ldLbu:   return {24'd0, b};
            ldLh:    return {{16{h[15]}}, h};
            ldLhu:   return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] readCp0(input logic [4:0] sel);
        case (sel)
            cp0BadVAddr: return mBadVAddr;
            cp0Status:   return mStatus;
            cp0Cause:    return mCause;
            cp0Epc:      return mEpc;
            default:     return 32'd0;
        endcase
    endfunction

    function automatic exeToMem randomInstr();
        exeToMem     i;
        int          kind;
        logic [2:0]  top;
        i = '0;
        kind = int'($urandom_range(0, 15));
        case ($urandom_range(0, 3))
            0:       top = 3'b000;
            1:       top = 3'b100;
            2:       top = 3'b101;
            default: top = 3'b110;
        endcase
        i.valid = 1'b1;
        i.pc = $urandom & 32'hFFFF_FFFC;
        i.aluOut = {top, 29'($urandom)};
        if ($urandom_range(0, 3) != 0) i.aluOut[1:0] = 2'b00;   // mostly aligned
        i.storeData = $urandom;
        i.dst = 5'($urandom);
        i.regWrite = 1'($urandom);
        i.inDelaySlot = $urandom_range(0, 3) == 0;
        i.ovf = $urandom_range(0, 15) == 0;
        i.sys = $urandom_range(0, 15) == 0;
        i.brk = $urandom_range(0, 15) == 0;
        i.ri = $urandom_range(0, 15) == 0;
        case ($urandom_range(0, 4))
            0:       i.cp0Sel = cp0BadVAddr;
            1:       i.cp0Sel = cp0Status;
            2:       i.cp0Sel = cp0Cause;
            3:       i.cp0Sel = cp0Epc;
            default: i.cp0Sel = 5'($urandom);
        endcase
        if (kind >= 4 && kind <= 7) i.loadKind = loadKind'(3'($urandom_range(1, 5)));
        else if (kind >= 8 && kind <= 10) i.storeKind = storeKind'(2'($urandom_range(1, 3)));
        else if (kind == 11 || kind == 12) i.cp0Op = copMfc0;
        else if (kind == 13 || kind == 14) i.cp0Op = copMtc0;
        else if (kind == 15) i.cp0Op = copEret;
        return i;
    endfunction

    task automatic checkWb();
        checkBit("wb valid", expWb.valid, memOut.valid);
        if (expWb.valid) begin
            checkValue("wb dst", {27'd0, expWb.dst}, {27'd0, memOut.dst});
            checkBit("wb regWrite", expWb.regWrite, memOut.regWrite);
            if (expWb.regWrite) checkValue("wb result", expWb.result, memOut.result);
        end
    endtask

    task automatic updateCp0(input logic taken, input logic [4:0] code, input logic isEret);
        if (!taken && stage.cp0Op == copMtc0) begin
            case (stage.cp0Sel)
                cp0Status: mStatus = (mStatus & ~statusWrMask) | (stage.storeData & statusWrMask);
                cp0Cause:  mCause = (mCause & ~causeWrMask) | (stage.storeData & causeWrMask);
                cp0Epc:    mEpc = stage.storeData;
                default:   ;
            endcase
        end
        if (taken) begin
            mEpc = stage.inDelaySlot ? stage.pc - 32'd4 : stage.pc;
            mCause[31] = stage.inDelaySlot;
            mCause[6:2] = code;
            mStatus[1] = 1'b1;
            if (code == excAdel || code == excAdes) mBadVAddr = stage.aluOut;
        end
        if (isEret) mStatus[1] = 1'b0;
    endtask

    // one clock: drive at the falling edge, then predict the next rising edge
    task automatic runCycle();
        logic [5:0]  exc;
        logic        taken;
        logic        isEret;
        logic        isLoad;
        logic        isStore;
        logic        busDone;
        logic        complete;
        logic        expFlush;
        logic [31:0] pa;
        logic [3:0]  strb;
        logic [31:0] data;
        checkWb();
        if (busReq.psel && !busReq.penable) waitCnt = int'($urandom_range(0, 3));
        busRsp.pready = busReq.psel && busReq.penable && waitCnt == 0;
        busRsp.prdata = slaveMem[busReq.paddr[9:2]];
        busRsp.pslverr = 1'b0;
        if ($urandom_range(0, 7) == 0) hwInt = ($urandom_range(0, 2) == 0) ? 6'($urandom) : 6'd0;
        if (!pending.valid && issued < numInstr) begin
            pending = randomInstr();
            issued++;
        end
        exeIn = pending;
        #1;
        exc = pickException(stage);
        taken = exc[5];
        isEret = stage.valid && stage.cp0Op == copEret && !taken;
        isLoad = stage.loadKind != ldNone;
        isStore = stage.storeKind != stNone;
        if (stage.valid && stageAge == 0) begin
            needBus = (isLoad || isStore) && !misalignedFor(stage) && !taken;
        end
        pa = mapAddr(stage.aluOut);
        checkBit("psel", stage.valid && needBus, busReq.psel);
        if (stage.valid && needBus) begin
            checkBit("penable", stageAge > 0, busReq.penable);
            checkValue("paddr", pa, busReq.paddr);
            checkBit("pwrite", isStore, busReq.pwrite);
            if (isStore) begin
                checkValue("pstrb", {28'd0, strobeFor(stage.storeKind, pa[1:0])},
                           {28'd0, busReq.pstrb});
                checkValue("pwdata", laneData(stage.storeKind, stage.storeData),
                           busReq.pwdata);
            end
        end
        busDone = stage.valid && needBus && stageAge > 0 && busRsp.pready;
        if (busDone && isStore) begin
            strb = strobeFor(stage.storeKind, pa[1:0]);
            data = laneData(stage.storeKind, stage.storeData);
            for (int b = 0; b < 4; b++) begin
                if (busReq.pstrb[b]) slaveMem[busReq.paddr[9:2]][8*b +: 8] = busReq.pwdata[8*b +: 8];
                if (strb[b]) refMem[pa[9:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
        complete = stage.valid && (!needBus || busDone);
        checkBit("memStall", stage.valid && !complete, memStall);
        expFlush = complete && (taken || isEret);
        checkBit("flushException", expFlush, flushException);
        if (expFlush) begin
            checkValue("exceptionVector", isEret ? mEpc : (mStatus[22] ? vecBoot : vecNormal),
                       exceptionVector);
        end
        checkValue("epc", mEpc, epc);
        expWb.valid = complete;
        expWb.dst = stage.dst;
        expWb.regWrite = stage.regWrite && !expFlush;
        if (isLoad) expWb.result = loadValue(stage.loadKind, refMem[pa[9:2]], pa[1:0]);
        else if (stage.cp0Op == copMfc0) expWb.result = readCp0(stage.cp0Sel);
        else expWb.result = stage.aluOut;
        if (complete) updateCp0(taken, exc[4:0], isEret);
        mCause[15:10] = hwInt;      // ip bits sample the pins each edge
        if (busReq.psel && busReq.penable && !busRsp.pready && waitCnt > 0) waitCnt--;
        if (!stage.valid || complete) begin
            stage = expFlush ? '0 : pending;    // flushed instruction is dropped
            pending = '0;
            stageAge = 0;
        end else begin
            stageAge++;
        end
    endtask

    initial begin
        void'($urandom(32'hda60));
        for (int i = 0; i < 256; i++) begin
            slaveMem[i] = (32'(i) * 32'h9E37_79B9) ^ {16'(i), 16'hC3A5};
            refMem[i] = slaveMem[i];
        end
        rst = 1'b1;
        exeIn = '0;
        hwInt = 6'd0;
        busRsp = '0;
        pending = '0;
        stage = '0;
        expWb = '0;
        stageAge = 0;
        needBus = 1'b0;
        waitCnt = 0;
        issued = 0;
        errors = 0;
        checks = 0;
        mStatus = statusReset;
        mCause = 32'd0;
        mEpc = 32'd0;
        mBadVAddr = 32'd0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (issued < numInstr || pending.valid || stage.valid) begin
            @(negedge clk);
            runCycle();
        end
        @(negedge clk);
        checkWb();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // longest legal run plus reset
    initial begin
        #((numInstr * cyclesPerInstr + 8) * 4);
        $display("timeout: the run did not finish in time");
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== memStage.f ====
hw/pipeTypesPkg.sv
hw/cp0DefsPkg.sv
hw/memPipeReg.sv
hw/addrTranslate.sv
hw/dataBusMaster.sv
hw/exceptionUnit.sv
hw/cp0Regs.sv
hw/memStageTop.sv
verification/memStageChk.sv
verification/memStageTb.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module memStageTb -f memStage.f

run: compile
	./obj_dir/VmemStageTb | tee /dev/stderr | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
